/* include/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// architectural register count
`define CPU_NUM_REGS 32

// jal stores its return address here
`define CPU_LINK_REG 31

// clock edges from the instruction strobe to the write-back port
`define CPU_WB_LATENCY 3

`define ZERO_WORD 32'h0000_0000

`endif

/* rtl/cpu_pkg.sv */
package cpu_pkg;

	typedef logic [31:0] Word_t;
	typedef logic [31:0] InstAddr_t;
	typedef logic [4:0]  RegAddr_t;
	typedef logic [15:0] HalfWord_t;

	typedef struct packed {
		logic [5:0] opcode;
		RegAddr_t   rs;
		RegAddr_t   rt;
		RegAddr_t   rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} InstR_t;

	typedef struct packed {
		logic [5:0] opcode;
		RegAddr_t   rs;
		RegAddr_t   rt;
		HalfWord_t  immediate;
	} InstI_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] instr_index;
	} InstJ_t;

	// one instruction word read three ways
	typedef union packed {
		InstR_t r_fmt;
		InstI_t i_fmt;
		InstJ_t j_fmt;
	} Inst_t;

	typedef enum logic [4:0] {
		OP_INVALID,
		OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
		OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLT,
		OP_SLL, OP_SRL, OP_SRA,
		OP_J, OP_JAL
	} Oper_t;

	typedef struct packed {
		logic     we;
		RegAddr_t waddr;
		Word_t    wdata;
	} RegWriteReq_t;

	// decode result handed to the execute stage
	typedef struct packed {
		Oper_t      op;
		Word_t      reg1;
		Word_t      reg2;
		logic       we;
		RegAddr_t   waddr;
		InstAddr_t  pc;
		logic [4:0] shamt;
	} IdEx_t;

endpackage

/* rtl/id_type_i.sv */
`timescale 1ns/100ps

module id_type_i (
	input  cpu_pkg::Inst_t inst_i,
	output cpu_pkg::Oper_t op_o,
	output logic           unsigned_imm_o
);

	always_comb begin
		op_o = cpu_pkg::OP_INVALID;
		// logic ops and lui take the immediate as an unsigned field
		unsigned_imm_o = 1'b0;
		case (inst_i.i_fmt.opcode)
			6'b001001: begin
				op_o = cpu_pkg::OP_ADDIU;
			end
			6'b001010: begin
				op_o = cpu_pkg::OP_SLTI;
			end
			6'b001100: begin
				op_o = cpu_pkg::OP_ANDI;
				unsigned_imm_o = 1'b1;
			end
			6'b001101: begin
				op_o = cpu_pkg::OP_ORI;
				unsigned_imm_o = 1'b1;
			end
			6'b001110: begin
				op_o = cpu_pkg::OP_XORI;
				unsigned_imm_o = 1'b1;
			end
			6'b001111: begin
				op_o = cpu_pkg::OP_LUI;
				unsigned_imm_o = 1'b1;
			end
			default: begin
				op_o = cpu_pkg::OP_INVALID;
			end
		endcase
	end

endmodule

/* rtl/id_type_r.sv */
`timescale 1ns/100ps

module id_type_r (
	input  cpu_pkg::Inst_t inst_i,
	output cpu_pkg::Oper_t op_o
);

	logic is_special;
	logic rs_zero;

	// all register-register ops live under opcode 0
	assign is_special = (inst_i.r_fmt.opcode == 6'b000000);
	assign rs_zero = (inst_i.r_fmt.rs == 5'd0);

	always_comb begin
		op_o = cpu_pkg::OP_INVALID;
		if (is_special) begin
			case (inst_i.r_fmt.funct)
				6'b100001: op_o = cpu_pkg::OP_ADDU;
				6'b100011: op_o = cpu_pkg::OP_SUBU;
				6'b100100: op_o = cpu_pkg::OP_AND;
				6'b100101: op_o = cpu_pkg::OP_OR;
				6'b100110: op_o = cpu_pkg::OP_XOR;
				6'b100111: op_o = cpu_pkg::OP_NOR;
				6'b101010: op_o = cpu_pkg::OP_SLT;
				// shift encodings require the rs field to be clear
				6'b000000: op_o = rs_zero ? cpu_pkg::OP_SLL : cpu_pkg::OP_INVALID;
				6'b000010: op_o = rs_zero ? cpu_pkg::OP_SRL : cpu_pkg::OP_INVALID;
				6'b000011: op_o = rs_zero ? cpu_pkg::OP_SRA : cpu_pkg::OP_INVALID;
				default:   op_o = cpu_pkg::OP_INVALID;
			endcase
		end
	end

endmodule

/* rtl/cpu_id.sv */
`timescale 1ns/100ps

`include "cpu_cfg.svh"

module cpu_id (
	input  cpu_pkg::InstAddr_t    pc_i,
	input  cpu_pkg::Inst_t        inst_i,
	input  cpu_pkg::Word_t        reg1_i,
	input  cpu_pkg::Word_t        reg2_i,
	output cpu_pkg::RegAddr_t     reg_raddr1_o,
	output cpu_pkg::RegAddr_t     reg_raddr2_o,
	input  cpu_pkg::RegWriteReq_t ex_wr_i,
	input  cpu_pkg::RegWriteReq_t mem_wr_i,
	output cpu_pkg::IdEx_t        id_ex_o
);

	cpu_pkg::Word_t fwd_rs;
	cpu_pkg::Word_t fwd_rt;
	cpu_pkg::Word_t imm_zero_ext;
	cpu_pkg::Word_t imm_sign_ext;
	cpu_pkg::Oper_t op_type_i;
	cpu_pkg::Oper_t op_type_j;
	cpu_pkg::Oper_t op_type_r;
	logic           unsigned_imm;

	// newest value of a source register where the younger stage wins
	function automatic cpu_pkg::Word_t forward_operand(
		input cpu_pkg::RegAddr_t     addr,
		input cpu_pkg::Word_t        rf_data,
		input cpu_pkg::RegWriteReq_t ex_wr,
		input cpu_pkg::RegWriteReq_t mem_wr
	);
		cpu_pkg::Word_t value;
		if (addr == 5'd0) begin
			value = `ZERO_WORD;
		end else if (ex_wr.we && ex_wr.waddr == addr) begin
			value = ex_wr.wdata;
		end else if (mem_wr.we && mem_wr.waddr == addr) begin
			value = mem_wr.wdata;
		end else begin
			value = rf_data;
		end
		return value;
	endfunction

	assign reg_raddr1_o = inst_i.r_fmt.rs;
	assign reg_raddr2_o = inst_i.r_fmt.rt;

	assign fwd_rs = forward_operand(reg_raddr1_o, reg1_i, ex_wr_i, mem_wr_i);
	assign fwd_rt = forward_operand(reg_raddr2_o, reg2_i, ex_wr_i, mem_wr_i);

	assign imm_zero_ext = {16'h0000, inst_i.i_fmt.immediate};
	assign imm_sign_ext = {{16{inst_i.i_fmt.immediate[15]}}, inst_i.i_fmt.immediate};

	id_type_i id_type_i_inst (
		.inst_i         (inst_i),
		.op_o           (op_type_i),
		.unsigned_imm_o (unsigned_imm)
	);

	id_type_r id_type_r_inst (
		.inst_i (inst_i),
		.op_o   (op_type_r)
	);

	// only j (000010) and jal (000011) are jump-format here
	always_comb begin
		case (inst_i.j_fmt.opcode)
			6'b000010: op_type_j = cpu_pkg::OP_J;
			6'b000011: op_type_j = cpu_pkg::OP_JAL;
			default:   op_type_j = cpu_pkg::OP_INVALID;
		endcase
	end

	always_comb begin
		id_ex_o.pc = pc_i;
		id_ex_o.shamt = inst_i.r_fmt.shamt;
		if (op_type_i != cpu_pkg::OP_INVALID) begin
			id_ex_o.op = op_type_i;
			id_ex_o.reg1 = fwd_rs;
			id_ex_o.reg2 = unsigned_imm ? imm_zero_ext : imm_sign_ext;
			id_ex_o.we = 1'b1;
			id_ex_o.waddr = inst_i.i_fmt.rt;
		end else if (op_type_j != cpu_pkg::OP_INVALID) begin
			id_ex_o.op = op_type_j;
			id_ex_o.reg1 = `ZERO_WORD;
			id_ex_o.reg2 = `ZERO_WORD;
			// bit 0 of the opcode tells jal from j and only jal links
			id_ex_o.we = inst_i.j_fmt.opcode[0];
			id_ex_o.waddr = 5'(`CPU_LINK_REG);
		end else if (op_type_r != cpu_pkg::OP_INVALID) begin
			id_ex_o.op = op_type_r;
			id_ex_o.reg1 = fwd_rs;
			id_ex_o.reg2 = fwd_rt;
			id_ex_o.we = 1'b1;
			id_ex_o.waddr = inst_i.r_fmt.rd;
		end else begin
			id_ex_o.op = cpu_pkg::OP_INVALID;
			id_ex_o.reg1 = `ZERO_WORD;
			id_ex_o.reg2 = `ZERO_WORD;
			id_ex_o.we = 1'b0;
			id_ex_o.waddr = 5'd0;
		end
	end

endmodule

/* rtl/cpu_regfile.sv */
`timescale 1ns/100ps

`include "cpu_cfg.svh"

module cpu_regfile (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  cpu_pkg::RegAddr_t     raddr1_i,
	input  cpu_pkg::RegAddr_t     raddr2_i,
	output cpu_pkg::Word_t        rdata1_o,
	output cpu_pkg::Word_t        rdata2_o,
	input  cpu_pkg::RegWriteReq_t wr_i
);

	cpu_pkg::Word_t regs [`CPU_NUM_REGS];

	// register 0 is never written, so it stays at its reset value
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < `CPU_NUM_REGS; i++) begin
				regs[i] <= `ZERO_WORD;
			end
		end else if (wr_i.we && wr_i.waddr != 5'd0) begin
			regs[wr_i.waddr] <= wr_i.wdata;
		end
	end

	// write-through so a read in the write-back cycle sees the new value
	always_comb begin
		if (raddr1_i == 5'd0) begin
			rdata1_o = `ZERO_WORD;
		end else if (wr_i.we && wr_i.waddr == raddr1_i) begin
			rdata1_o = wr_i.wdata;
		end else begin
			rdata1_o = regs[raddr1_i];
		end
		if (raddr2_i == 5'd0) begin
			rdata2_o = `ZERO_WORD;
		end else if (wr_i.we && wr_i.waddr == raddr2_i) begin
			rdata2_o = wr_i.wdata;
		end else begin
			rdata2_o = regs[raddr2_i];
		end
	end

endmodule

/* rtl/cpu_ex_pipe.sv */
`timescale 1ns/100ps

module cpu_ex_pipe (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  logic                  id_valid_i,
	input  cpu_pkg::IdEx_t        id_ex_i,
	output cpu_pkg::RegWriteReq_t ex_wr_o,
	output cpu_pkg::RegWriteReq_t mem_wr_o,
	output cpu_pkg::RegWriteReq_t wb_o
);

	cpu_pkg::IdEx_t        id_ex_q;
	cpu_pkg::RegWriteReq_t mem_q;
	cpu_pkg::RegWriteReq_t wb_q;
	cpu_pkg::Word_t        alu_result;
	logic                  ex_valid_q;
	logic                  mem_valid_q;
	logic                  wb_valid_q;

	// valid bits per stage
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ex_valid_q <= 1'b0;
			mem_valid_q <= 1'b0;
			wb_valid_q <= 1'b0;
		end else begin
			ex_valid_q <= id_valid_i;
			mem_valid_q <= ex_valid_q;
			wb_valid_q <= mem_valid_q;
		end
	end

	// stage payloads advance every cycle
	always_ff @(posedge clk) begin
		id_ex_q <= id_ex_i;
		mem_q <= '{we: id_ex_q.we, waddr: id_ex_q.waddr, wdata: alu_result};
		wb_q <= mem_q;
	end

	always_comb begin
		case (id_ex_q.op)
			cpu_pkg::OP_ADDU, cpu_pkg::OP_ADDIU: alu_result = id_ex_q.reg1 + id_ex_q.reg2;
			cpu_pkg::OP_SUBU: alu_result = id_ex_q.reg1 - id_ex_q.reg2;
			cpu_pkg::OP_SLT, cpu_pkg::OP_SLTI: begin
				alu_result = {31'd0, $signed(id_ex_q.reg1) < $signed(id_ex_q.reg2)};
			end
			cpu_pkg::OP_AND, cpu_pkg::OP_ANDI: alu_result = id_ex_q.reg1 & id_ex_q.reg2;
			cpu_pkg::OP_OR, cpu_pkg::OP_ORI:   alu_result = id_ex_q.reg1 | id_ex_q.reg2;
			cpu_pkg::OP_XOR, cpu_pkg::OP_XORI: alu_result = id_ex_q.reg1 ^ id_ex_q.reg2;
			cpu_pkg::OP_NOR: alu_result = ~(id_ex_q.reg1 | id_ex_q.reg2);
			cpu_pkg::OP_LUI: alu_result = {id_ex_q.reg2[15:0], 16'h0000};
			cpu_pkg::OP_SLL: alu_result = id_ex_q.reg2 << id_ex_q.shamt;
			cpu_pkg::OP_SRL: alu_result = id_ex_q.reg2 >> id_ex_q.shamt;
			cpu_pkg::OP_SRA: alu_result = $signed(id_ex_q.reg2) >>> id_ex_q.shamt;
			// return address skips the delay slot
			cpu_pkg::OP_JAL: alu_result = id_ex_q.pc + 32'd8;
			default:         alu_result = '0;
		endcase
	end

	assign ex_wr_o = '{we: ex_valid_q & id_ex_q.we, waddr: id_ex_q.waddr, wdata: alu_result};
	assign mem_wr_o = '{we: mem_valid_q & mem_q.we, waddr: mem_q.waddr, wdata: mem_q.wdata};
	assign wb_o = '{we: wb_valid_q & wb_q.we, waddr: wb_q.waddr, wdata: wb_q.wdata};

endmodule

/* rtl/cpu_core.sv */
`timescale 1ns/100ps

module cpu_core (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  logic                  inst_valid_i,
	input  cpu_pkg::InstAddr_t    pc_i,
	input  cpu_pkg::Inst_t        inst_i,
	output cpu_pkg::RegWriteReq_t wb_o
);

	cpu_pkg::RegAddr_t     reg_raddr1;
	cpu_pkg::RegAddr_t     reg_raddr2;
	cpu_pkg::Word_t        reg1;
	cpu_pkg::Word_t        reg2;
	cpu_pkg::RegWriteReq_t ex_wr;
	cpu_pkg::RegWriteReq_t mem_wr;
	cpu_pkg::IdEx_t        id_ex;

	// decode and operand forwarding
	cpu_id cpu_id_inst (
		.pc_i         (pc_i),
		.inst_i       (inst_i),
		.reg1_i       (reg1),
		.reg2_i       (reg2),
		.reg_raddr1_o (reg_raddr1),
		.reg_raddr2_o (reg_raddr2),
		.ex_wr_i      (ex_wr),
		.mem_wr_i     (mem_wr),
		.id_ex_o      (id_ex)
	);

	// write port is driven straight from write-back
	cpu_regfile cpu_regfile_inst (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.raddr1_i (reg_raddr1),
		.raddr2_i (reg_raddr2),
		.rdata1_o (reg1),
		.rdata2_o (reg2),
		.wr_i     (wb_o)
	);

	cpu_ex_pipe cpu_ex_pipe_inst (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.id_valid_i (inst_valid_i),
		.id_ex_i    (id_ex),
		.ex_wr_o    (ex_wr),
		.mem_wr_o   (mem_wr),
		.wb_o       (wb_o)
	);

endmodule

/* tests/cpu_core_assert.sv */
`timescale 1ns/100ps

`include "cpu_cfg.svh"

module cpu_core_assert (
	input logic                  clk,
	input logic                  arst_n_i,
	input logic                  inst_valid_i,
	input cpu_pkg::InstAddr_t    pc_i,
	input cpu_pkg::Inst_t        inst_i,
	input cpu_pkg::RegWriteReq_t wb_o
);

	int fail_count = 0;

	// pipeline is empty right after reset
	wb_quiet_after_reset: assert property (@(posedge clk) $rose(arst_n_i) |-> !wb_o.we [*3])
		else begin
			fail_count++;
			$error("write-back active within three cycles of reset release");
		end

	wb_data_known: assert property (@(posedge clk) disable iff (!arst_n_i)
		wb_o.we |-> !$isunknown(wb_o.wdata))
		else begin
			fail_count++;
			$error("write-back data unknown while we is high");
		end

	// jal retires its return address to the link register
	jal_link_value: assert property (@(posedge clk) disable iff (!arst_n_i)
		inst_valid_i && inst_i.j_fmt.opcode == 6'b000011 |-> ##(`CPU_WB_LATENCY)
		wb_o.we && wb_o.waddr == 5'(`CPU_LINK_REG)
		&& wb_o.wdata == $past(pc_i, `CPU_WB_LATENCY) + 32'd8)
		else begin
			fail_count++;
			$error("jal link write missing or wrong");
		end

endmodule

bind cpu_core cpu_core_assert asrt0 (
	.clk          (clk),
	.arst_n_i     (arst_n_i),
	.inst_valid_i (inst_valid_i),
	.pc_i         (pc_i),
	.inst_i       (inst_i),
	.wb_o         (wb_o)
);

/* tests/cpu_core_tb.sv */
`timescale 1ns/100ps

`include "cpu_cfg.svh"

module cpu_core_tb;

	typedef struct packed {
		logic [31:0]       cycle;
		cpu_pkg::RegAddr_t waddr;
		cpu_pkg::Word_t    wdata;
	} ExpWrite_t;

	localparam int NUM_STROBES = 251;
	localparam int TIMEOUT_NS = (NUM_STROBES * 5 + 200) * 8;

	logic                  clk = 1'b0;
	logic                  arst_n_i;
	logic                  inst_valid_i;
	cpu_pkg::InstAddr_t    pc_i;
	cpu_pkg::Inst_t        inst_i;
	cpu_pkg::RegWriteReq_t wb_o;

	logic [31:0]       lfsr = 32'd98906;
	logic [31:0]       cyc = '0;
	logic [31:0]       last_strobe = '0;
	cpu_pkg::Word_t    model_regs [`CPU_NUM_REGS] = '{default: '0};
	ExpWrite_t         exp_q [$];
	ExpWrite_t         mon_e;
	logic [5:0]        itype_ops [6] = '{6'h09, 6'h0a, 6'h0c, 6'h0d, 6'h0e, 6'h0f};
	logic [5:0]        rtype_fns [10] = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a,
		6'h00, 6'h02, 6'h03};
	logic [5:0]        fn;
	cpu_pkg::RegAddr_t rs;
	int                errors = 0;
	int                compared = 0;
	int                strobes = 0;
	int                test_err = 0;

	cpu_core dut0 (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.inst_valid_i (inst_valid_i),
		.pc_i         (pc_i),
		.inst_i       (inst_i),
		.wb_o         (wb_o)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	// architectural model executing in program order at strobe time
	task automatic model_exec(input cpu_pkg::Word_t w, input cpu_pkg::InstAddr_t pc,
		output logic we, output cpu_pkg::RegAddr_t wa, output cpu_pkg::Word_t wd);
		cpu_pkg::Word_t a;
		cpu_pkg::Word_t b;
		cpu_pkg::Word_t se;
		cpu_pkg::Word_t ze;
		a = model_regs[w[25:21]];
		b = model_regs[w[20:16]];
		se = {{16{w[15]}}, w[15:0]};
		ze = {16'h0000, w[15:0]};
		we = 1'b1;
		wa = w[20:16];
		wd = '0;
		case (w[31:26])
			6'h09: wd = a + se;
			6'h0a: wd = {31'd0, $signed(a) < $signed(se)};
			6'h0c: wd = a & ze;
			6'h0d: wd = a | ze;
			6'h0e: wd = a ^ ze;
			6'h0f: wd = {w[15:0], 16'h0000};
			6'h03: begin
				wa = 5'(`CPU_LINK_REG);
				wd = pc + 32'd8;
			end
			6'h00: begin
				wa = w[15:11];
				case (w[5:0])
					6'h21: wd = a + b;
					6'h23: wd = a - b;
					6'h24: wd = a & b;
					6'h25: wd = a | b;
					6'h26: wd = a ^ b;
					6'h27: wd = ~(a | b);
					6'h2a: wd = {31'd0, $signed(a) < $signed(b)};
					6'h00: wd = b << w[10:6];
					6'h02: wd = b >> w[10:6];
					6'h03: wd = $signed(b) >>> w[10:6];
					default: we = 1'b0;
				endcase
				// shift encodings are only legal with rs clear
				if (w[5:0] inside {6'h00, 6'h02, 6'h03} && w[25:21] != 5'd0) begin
					we = 1'b0;
				end
			end
			default: we = 1'b0;
		endcase
		if (we && wa != 5'd0) begin
			model_regs[wa] = wd;
		end
	endtask

	task automatic issue(input cpu_pkg::Word_t w, input int gap);
		logic              we;
		cpu_pkg::RegAddr_t wa;
		cpu_pkg::Word_t    wd;
		inst_valid_i = 1'b1;
		inst_i = w;
		model_exec(w, pc_i, we, wa, wd);
		if (we) begin
			exp_q.push_back('{cycle: cyc + `CPU_WB_LATENCY, waddr: wa, wdata: wd});
		end
		last_strobe = cyc;
		strobes++;
		@(negedge clk);
		inst_valid_i = 1'b0;
		pc_i = pc_i + 32'd4;
		repeat (gap) @(negedge clk);
	endtask

	// wait until every expected write has retired, then report the test
	task automatic finish_test(input string name);
		while (exp_q.size() != 0 || cyc <= last_strobe + `CPU_WB_LATENCY) begin
			@(negedge clk);
		end
		$display("%s: done, %0d errors", name, errors - test_err);
		test_err = errors;
	endtask

	// write-back monitor sampling mid-cycle
	always @(negedge clk) begin
		if (exp_q.size() != 0 && exp_q[0].cycle == cyc) begin
			mon_e = exp_q.pop_front();
			assert (wb_o.we === 1'b1) else begin
				$display("at time %0d ns a write of %h to r%0d never arrived", $time,
					mon_e.wdata, mon_e.waddr);
				errors++;
			end
			if (wb_o.we === 1'b1) begin
				compared++;
				assert (wb_o.waddr == mon_e.waddr && wb_o.wdata == mon_e.wdata) else begin
					$display("FAILED at %0d ns: expected r%0d=%h, got r%0d=%h", $time,
						mon_e.waddr, mon_e.wdata, wb_o.waddr, wb_o.wdata);
					errors++;
				end
			end
		end else begin
			assert (wb_o.we === 1'b0) else begin
				$display("at time %0d ns a write to r%0d appeared that nothing asked for",
					$time, wb_o.waddr);
				errors++;
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog: run still going after %0d ns, stopped", TIMEOUT_NS);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		arst_n_i = 1'b0;
		inst_valid_i = 1'b0;
		inst_i = '0;
		pc_i = 32'h0040_0000;
		repeat (10) @(negedge clk);
		arst_n_i = 1'b1;
		repeat (4) @(negedge clk);
		issue({6'h0d, 5'd0, 5'd1, 16'h1234}, 0);
		finish_test("reset");
		// only registers 0..7 so hazards come often
		repeat (60) begin
			issue({itype_ops[rand_bits(3) % 6], 2'b00, 3'(rand_bits(3)), 2'b00,
				3'(rand_bits(3)), 16'(rand_bits(16))}, rand_bits(2));
		end
		finish_test("itype_random");
		repeat (80) begin
			fn = rtype_fns[rand_bits(4) % 10];
			rs = (fn inside {6'h00, 6'h02, 6'h03}) ? 5'd0 : 5'(rand_bits(3));
			issue({6'h00, rs, 5'(rand_bits(3)), 5'(rand_bits(3)), 5'(rand_bits(5)), fn},
				rand_bits(2));
		end
		finish_test("rtype_random");
		// dependency chain at each gap covers ex, mem, write-through and plain read
		for (int g = 0; g < 4; g++) begin
			issue({6'h0d, 5'd0, 5'd1, 16'(rand_bits(16))}, g);
			issue({6'h09, 5'd1, 5'd1, 16'(rand_bits(16))}, g);
			issue({6'h09, 5'd1, 5'd1, 16'(rand_bits(16))}, g);
			issue({6'h00, 5'd1, 5'd1, 5'd2, 5'd0, 6'h21}, g);
			issue({6'h00, 5'd2, 5'd1, 5'd3, 5'd0, 6'h26}, g);
			issue({6'h00, 5'd0, 5'd3, 5'd4, 5'd4, 6'h03}, g);
		end
		finish_test("hazard_gaps");
		repeat (8) begin
			issue({6'h03, 26'(rand_bits(26))}, 0);
			issue({6'h00, 5'd31, 5'd1, 5'd5, 5'd0, 6'h21}, rand_bits(2));
			issue({6'h02, 26'(rand_bits(26))}, rand_bits(2));
			issue({6'h20 | 6'(rand_bits(5)), 26'(rand_bits(26))}, rand_bits(2));
			issue({6'h00, 5'd1, 5'd2, 5'd6, 5'd0, 6'h18 | 6'(rand_bits(3))}, rand_bits(2));
			issue({6'h00, 5'd3, 5'd2, 5'd6, 5'd1, 6'h00}, rand_bits(2));
			issue({6'h0e, 5'd5, 5'd7, 16'(rand_bits(16))}, 0);
		end
		finish_test("jump_invalid");
		// r0 writes show on the port but never feed a later read
		repeat (10) begin
			issue({6'h0d, 5'd1, 5'd0, 16'(rand_bits(16))}, 0);
			issue({6'h00, 5'd0, 5'd0, 5'd4, 5'd0, 6'h27}, rand_bits(2));
			issue({6'h09, 5'd0, 5'd5, 16'(rand_bits(16))}, rand_bits(2));
		end
		finish_test("zero_register");
		errors = errors + dut0.asrt0.fail_count;
		$display("summary: %0d strobes, %0d writes compared, %0d errors", strobes, compared,
			errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* project.f */
+incdir+include
rtl/cpu_pkg.sv
rtl/id_type_i.sv
rtl/id_type_r.sv
rtl/cpu_id.sv
rtl/cpu_regfile.sv
rtl/cpu_ex_pipe.sv
rtl/cpu_core.sv
tests/cpu_core_assert.sv
tests/cpu_core_tb.sv
